// ==== dlx_pipe.f ====
+incdir+hw
hw/dlx_pkg.sv
hw/dlx_stage_if.sv
hw/dlx_regfile.sv
hw/dlx_alu.sv
hw/dlx_fetch_decode.sv
hw/dlx_execute_mem.sv
hw/dlx_cpu_top.sv
tests/dlx_cpu_tb.sv

// ==== hw/dlx_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dlx_params.svh"

module dlx_alu (
   input  dlx_pkg::alu_op_e     op,
   input  logic [`DLX_XLEN-1:0] a,
   input  logic [`DLX_XLEN-1:0] b,
   output logic [`DLX_XLEN-1:0] result
);

   always_comb begin
      case (op)
         dlx_pkg::ALU_ADD: result = a + b;
         dlx_pkg::ALU_SUB: result = a - b;
         dlx_pkg::ALU_AND: result = a & b;
         dlx_pkg::ALU_OR:  result = a | b;
         dlx_pkg::ALU_XOR: result = a ^ b;
         // Signed compare, result is 0 or 1
         dlx_pkg::ALU_SLT: result = {{(`DLX_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         // Shift amount from the low five bits of b
         dlx_pkg::ALU_SLL: result = a << b[4:0];
         dlx_pkg::ALU_SRL: result = a >> b[4:0];
         dlx_pkg::ALU_PASSB: result = b;
         default:          result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/dlx_cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dlx_params.svh"

module dlx_cpu_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 imem_we,
   input  logic [`DLX_XLEN-1:0] imem_addr,
   input  logic [`DLX_XLEN-1:0] imem_wdata,
   output logic                 retire_valid,
   output logic [4:0]           retire_dest,
   output logic [`DLX_XLEN-1:0] retire_data,
   output logic                 store_valid,
   output logic [`DLX_XLEN-1:0] store_addr,
   output logic [`DLX_XLEN-1:0] store_data,
   output logic                 halted
);

   // Register file read side
   logic [4:0]           rf_rd_sel_a;
   logic [4:0]           rf_rd_sel_b;
   logic [`DLX_XLEN-1:0] rf_rd_data_a;
   logic [`DLX_XLEN-1:0] rf_rd_data_b;

   // Register file write side, fed from writeback
   logic                 rf_wr_en;
   logic [4:0]           rf_wr_sel;
   logic [`DLX_XLEN-1:0] rf_wr_data;

   dlx_stage_if st_if ();

   dlx_fetch_decode fetch_decode_i (
      .clk          (clk),
      .rst          (rst),
      .imem_we      (imem_we),
      .imem_addr    (imem_addr),
      .imem_wdata   (imem_wdata),
      .rf_rd_data_a (rf_rd_data_a),
      .rf_rd_data_b (rf_rd_data_b),
      .rf_rd_sel_a  (rf_rd_sel_a),
      .rf_rd_sel_b  (rf_rd_sel_b),
      .st           (st_if.producer)
   );

   dlx_regfile regfile_i (
      .clk       (clk),
      .rst       (rst),
      .rd_sel_a  (rf_rd_sel_a),
      .rd_sel_b  (rf_rd_sel_b),
      .wr_en     (rf_wr_en),
      .wr_sel    (rf_wr_sel),
      .wr_data   (rf_wr_data),
      .rd_data_a (rf_rd_data_a),
      .rd_data_b (rf_rd_data_b)
   );

   dlx_execute_mem execute_mem_i (
      .clk          (clk),
      .rst          (rst),
      .st           (st_if.consumer),
      .rf_wr_en     (rf_wr_en),
      .rf_wr_sel    (rf_wr_sel),
      .rf_wr_data   (rf_wr_data),
      .retire_valid (retire_valid),
      .retire_dest  (retire_dest),
      .retire_data  (retire_data),
      .store_valid  (store_valid),
      .store_addr   (store_addr),
      .store_data   (store_data),
      .halted       (halted)
   );

endmodule

`default_nettype wire

// ==== hw/dlx_execute_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dlx_params.svh"

module dlx_execute_mem (
   input  logic                 clk,
   input  logic                 rst,
   dlx_stage_if.consumer        st,
   output logic                 rf_wr_en,
   output logic [4:0]           rf_wr_sel,
   output logic [`DLX_XLEN-1:0] rf_wr_data,
   output logic                 retire_valid,
   output logic [4:0]           retire_dest,
   output logic [`DLX_XLEN-1:0] retire_data,
   output logic                 store_valid,
   output logic [`DLX_XLEN-1:0] store_addr,
   output logic [`DLX_XLEN-1:0] store_data,
   output logic                 halted
);

   localparam int DMEM_AW = $clog2(`DLX_DMEM_WORDS);

   logic [`DLX_XLEN-1:0] rs1_fwd;
   logic [`DLX_XLEN-1:0] rs2_fwd;
   logic [`DLX_XLEN-1:0] alu_b;
   logic [`DLX_XLEN-1:0] alu_result;

   // EX/MEM register
   logic                 exm_valid;
   dlx_pkg::ctrl_s       exm_ctrl;
   logic [`DLX_XLEN-1:0] exm_result;
   logic [`DLX_XLEN-1:0] exm_store;

   logic [`DLX_XLEN-1:0] dmem [`DLX_DMEM_WORDS];
   logic [`DLX_XLEN-1:0] load_data;
   logic [`DLX_XLEN-1:0] mem_value;

   // MEM/WB register
   logic                 mwb_valid;
   dlx_pkg::ctrl_s       mwb_ctrl;
   logic [`DLX_XLEN-1:0] mwb_value;
   logic                 halt_q;

   // MEM ahead of WB, otherwise the value read in decode
   function automatic logic [`DLX_XLEN-1:0] fwd_ex(input logic [4:0]           sel,
                                                   input logic [`DLX_XLEN-1:0] id_val);
      logic [`DLX_XLEN-1:0] val;
      val = id_val;
      if (sel != 5'd0) begin
         if (exm_valid && exm_ctrl.reg_write && exm_ctrl.dest == sel) begin
            val = mem_value;
         end else if (mwb_valid && mwb_ctrl.reg_write && mwb_ctrl.dest == sel) begin
            val = mwb_value;
         end
      end
      return val;
   endfunction

   assign rs1_fwd = fwd_ex(st.ex_rs1_sel, st.ex_rs1_val);
   assign rs2_fwd = fwd_ex(st.ex_rs2_sel, st.ex_rs2_val);
   assign alu_b   = st.ex_ctrl.alu_src_imm ? st.ex_imm : rs2_fwd;

   dlx_alu alu_i (
      .op     (st.ex_ctrl.alu_op),
      .a      (rs1_fwd),
      .b      (alu_b),
      .result (alu_result)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         exm_valid <= 1'b0;
      end else begin
         exm_valid <= st.ex_valid;
      end
   end

   // rs2 carries the store data
   always_ff @(posedge clk) begin
      exm_ctrl   <= st.ex_ctrl;
      exm_result <= alu_result;
      exm_store  <= rs2_fwd;
   end

   // Data memory, word addressed from the ALU result
   // Cleared so every run starts from zero
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `DLX_DMEM_WORDS; i++) begin
            dmem[i] <= '0;
         end
      end else if (store_valid) begin
         dmem[exm_result[DMEM_AW+1:2]] <= exm_store;
      end
   end

   assign load_data = dmem[exm_result[DMEM_AW+1:2]];
   assign mem_value = exm_ctrl.mem_read ? load_data : exm_result;

   always_ff @(posedge clk) begin
      if (rst) begin
         mwb_valid <= 1'b0;
      end else begin
         mwb_valid <= exm_valid;
      end
   end

   always_ff @(posedge clk) begin
      mwb_ctrl  <= exm_ctrl;
      mwb_value <= mem_value;
   end

   // Sticky once halt has retired
   always_ff @(posedge clk) begin
      if (rst) begin
         halt_q <= 1'b0;
      end else if (mwb_valid && mwb_ctrl.halt) begin
         halt_q <= 1'b1;
      end
   end

   // Feedback to decode
   assign st.ex_result = alu_result;
   assign st.mem_valid = exm_valid;
   assign st.mem_ctrl  = exm_ctrl;
   assign st.mem_value = mem_value;
   assign st.wb_valid  = mwb_valid;
   assign st.wb_ctrl   = mwb_ctrl;
   assign st.wb_value  = mwb_value;

   // Writes to r0 are dropped here
   assign rf_wr_en   = mwb_valid && mwb_ctrl.reg_write && mwb_ctrl.dest != 5'd0;
   assign rf_wr_sel  = mwb_ctrl.dest;
   assign rf_wr_data = mwb_value;

   assign retire_valid = rf_wr_en;
   assign retire_dest  = rf_wr_sel;
   assign retire_data  = rf_wr_data;

   assign store_valid = exm_valid && exm_ctrl.mem_write;
   assign store_addr  = exm_result;
   assign store_data  = exm_store;

   assign halted = halt_q || (mwb_valid && mwb_ctrl.halt);

endmodule

`default_nettype wire

// ==== hw/dlx_fetch_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dlx_params.svh"

module dlx_fetch_decode (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 imem_we,
   input  logic [`DLX_XLEN-1:0] imem_addr,
   input  logic [`DLX_XLEN-1:0] imem_wdata,
   input  logic [`DLX_XLEN-1:0] rf_rd_data_a,
   input  logic [`DLX_XLEN-1:0] rf_rd_data_b,
   output logic [4:0]           rf_rd_sel_a,
   output logic [4:0]           rf_rd_sel_b,
   dlx_stage_if.producer        st
);

   localparam int IMEM_AW = $clog2(`DLX_IMEM_WORDS);

   logic [`DLX_XLEN-1:0] imem [`DLX_IMEM_WORDS];
   logic [`DLX_XLEN-1:0] pc;
   logic [`DLX_XLEN-1:0] fetch_word;

   // IF/ID register
   logic                 ifid_valid;
   dlx_pkg::instr_u      ifid_instr;
   logic [`DLX_XLEN-1:0] ifid_pc4;

   // Decode results
   dlx_pkg::ctrl_s       dec_ctrl;
   logic                 uses_rs1;
   logic                 uses_rs2;
   logic                 is_branch;
   logic                 br_on_zero;
   logic [4:0]           rs1_sel;
   logic [4:0]           rs2_sel;
   logic [`DLX_XLEN-1:0] imm_sext;
   logic [`DLX_XLEN-1:0] rs1_val;
   logic [`DLX_XLEN-1:0] rs2_val;
   logic [`DLX_XLEN-1:0] br_target;

   // Hazard and flow control
   logic                 load_use;
   logic                 br_taken;
   logic                 halt_dec;
   logic                 halt_seen;
   logic                 fetch_stop;

   // Program load only while the core is held in reset
   always_ff @(posedge clk) begin
      if (rst && imem_we) begin
         imem[imem_addr[IMEM_AW+1:2]] <= imem_wdata;
      end
   end

   assign fetch_word = imem[pc[IMEM_AW+1:2]];

   // Youngest writer wins, r0 never forwarded
   function automatic logic [`DLX_XLEN-1:0] fwd_id(input logic [4:0]           sel,
                                                   input logic [`DLX_XLEN-1:0] rf_val);
      logic [`DLX_XLEN-1:0] val;
      val = rf_val;
      if (sel != 5'd0) begin
         if (st.ex_valid && st.ex_ctrl.reg_write && st.ex_ctrl.dest == sel) begin
            val = st.ex_result;
         end else if (st.mem_valid && st.mem_ctrl.reg_write && st.mem_ctrl.dest == sel) begin
            val = st.mem_value;
         end else if (st.wb_valid && st.wb_ctrl.reg_write && st.wb_ctrl.dest == sel) begin
            val = st.wb_value;
         end
      end
      return val;
   endfunction

   // Store data register (I view rd) sits in the same bits as R view rs2
   assign rs1_sel     = ifid_instr.r.rs1;
   assign rs2_sel     = ifid_instr.r.rs2;
   assign rf_rd_sel_a = rs1_sel;
   assign rf_rd_sel_b = rs2_sel;
   assign imm_sext    = {{(`DLX_XLEN-16){ifid_instr.i.imm16[15]}}, ifid_instr.i.imm16};

   always_comb begin
      dec_ctrl        = '0;
      dec_ctrl.alu_op = dlx_pkg::ALU_PASSB;
      uses_rs1        = 1'b0;
      uses_rs2        = 1'b0;
      is_branch       = 1'b0;
      br_on_zero      = 1'b0;
      case (ifid_instr.r.opcode)
         dlx_pkg::OP_RTYPE: begin
            dec_ctrl.reg_write = 1'b1;
            dec_ctrl.dest      = ifid_instr.r.rd;
            uses_rs1           = 1'b1;
            uses_rs2           = 1'b1;
            case (ifid_instr.r.funct)
               dlx_pkg::FN_ADD: dec_ctrl.alu_op = dlx_pkg::ALU_ADD;
               dlx_pkg::FN_SUB: dec_ctrl.alu_op = dlx_pkg::ALU_SUB;
               dlx_pkg::FN_AND: dec_ctrl.alu_op = dlx_pkg::ALU_AND;
               dlx_pkg::FN_OR:  dec_ctrl.alu_op = dlx_pkg::ALU_OR;
               dlx_pkg::FN_XOR: dec_ctrl.alu_op = dlx_pkg::ALU_XOR;
               dlx_pkg::FN_SLT: dec_ctrl.alu_op = dlx_pkg::ALU_SLT;
               dlx_pkg::FN_SLL: dec_ctrl.alu_op = dlx_pkg::ALU_SLL;
               dlx_pkg::FN_SRL: dec_ctrl.alu_op = dlx_pkg::ALU_SRL;
               // Unknown funct behaves as a nop
               default:         dec_ctrl.reg_write = 1'b0;
            endcase
         end
         dlx_pkg::OP_ADDI, dlx_pkg::OP_ANDI, dlx_pkg::OP_ORI,
         dlx_pkg::OP_XORI, dlx_pkg::OP_SLTI: begin
            dec_ctrl.reg_write   = 1'b1;
            dec_ctrl.alu_src_imm = 1'b1;
            dec_ctrl.dest        = ifid_instr.i.rd;
            uses_rs1             = 1'b1;
            case (ifid_instr.i.opcode)
               dlx_pkg::OP_ANDI: dec_ctrl.alu_op = dlx_pkg::ALU_AND;
               dlx_pkg::OP_ORI:  dec_ctrl.alu_op = dlx_pkg::ALU_OR;
               dlx_pkg::OP_XORI: dec_ctrl.alu_op = dlx_pkg::ALU_XOR;
               dlx_pkg::OP_SLTI: dec_ctrl.alu_op = dlx_pkg::ALU_SLT;
               default:          dec_ctrl.alu_op = dlx_pkg::ALU_ADD;
            endcase
         end
         dlx_pkg::OP_LW: begin
            dec_ctrl.reg_write   = 1'b1;
            dec_ctrl.mem_read    = 1'b1;
            dec_ctrl.alu_src_imm = 1'b1;
            dec_ctrl.alu_op      = dlx_pkg::ALU_ADD;
            dec_ctrl.dest        = ifid_instr.i.rd;
            uses_rs1             = 1'b1;
         end
         dlx_pkg::OP_SW: begin
            dec_ctrl.mem_write   = 1'b1;
            dec_ctrl.alu_src_imm = 1'b1;
            dec_ctrl.alu_op      = dlx_pkg::ALU_ADD;
            uses_rs1             = 1'b1;
            uses_rs2             = 1'b1;
         end
         dlx_pkg::OP_BEQZ: begin
            is_branch  = 1'b1;
            br_on_zero = 1'b1;
            uses_rs1   = 1'b1;
         end
         dlx_pkg::OP_BNEZ: begin
            is_branch = 1'b1;
            uses_rs1  = 1'b1;
         end
         dlx_pkg::OP_HALT: dec_ctrl.halt = 1'b1;
         default: ;
      endcase
   end

   assign rs1_val   = fwd_id(rs1_sel, rf_rd_data_a);
   assign rs2_val   = fwd_id(rs2_sel, rf_rd_data_b);
   assign br_target = ifid_pc4 + imm_sext;

   // Load in execute has no data yet, so a dependent reader waits a cycle
   assign load_use = ifid_valid && st.ex_valid && st.ex_ctrl.mem_read
                     && st.ex_ctrl.dest != 5'd0
                     && ((uses_rs1 && st.ex_ctrl.dest == rs1_sel)
                         || (uses_rs2 && st.ex_ctrl.dest == rs2_sel));

   // Branch resolves on the forwarded rs1
   assign br_taken   = ifid_valid && is_branch && !load_use
                       && ((rs1_val == '0) == br_on_zero);
   assign halt_dec   = ifid_valid && dec_ctrl.halt;
   assign fetch_stop = halt_seen || halt_dec;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (!load_use && !fetch_stop) begin
         pc <= br_taken ? br_target : pc + `DLX_XLEN'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         halt_seen <= 1'b0;
      end else if (halt_dec) begin
         halt_seen <= 1'b1;
      end
   end

   // Taken branch or halt kills the instruction fetched behind it
   always_ff @(posedge clk) begin
      if (rst) begin
         ifid_valid <= 1'b0;
      end else if (!load_use) begin
         ifid_valid <= !(br_taken || fetch_stop);
      end
   end

   always_ff @(posedge clk) begin
      if (!load_use) begin
         ifid_instr <= fetch_word;
         ifid_pc4   <= pc + `DLX_XLEN'd4;
      end
   end

   // Stall sends a bubble into execute
   always_ff @(posedge clk) begin
      if (rst) begin
         st.ex_valid <= 1'b0;
      end else begin
         st.ex_valid <= ifid_valid && !load_use;
      end
   end

   always_ff @(posedge clk) begin
      st.ex_ctrl    <= dec_ctrl;
      st.ex_rs1_sel <= rs1_sel;
      st.ex_rs2_sel <= rs2_sel;
      st.ex_rs1_val <= rs1_val;
      st.ex_rs2_val <= rs2_val;
      st.ex_imm     <= imm_sext;
   end

endmodule

`default_nettype wire

// ==== hw/dlx_params.svh ====
`ifndef DLX_PARAMS_SVH
`define DLX_PARAMS_SVH

// Data word and register width
`define DLX_XLEN 32

// Architectural registers, r0 reads as zero
`define DLX_NREGS 32

// Memory depths in words
// Byte addresses, bits 9:2 select the word
`define DLX_IMEM_WORDS 256
`define DLX_DMEM_WORDS 256

`endif

// ==== hw/dlx_pkg.sv ====
`default_nettype none

package dlx_pkg;

   // Major opcodes of the supported subset
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_BEQZ  = 6'h04,
      OP_BNEZ  = 6'h05,
      OP_ADDI  = 6'h08,
      OP_ANDI  = 6'h0c,
      OP_ORI   = 6'h0d,
      OP_XORI  = 6'h0e,
      OP_SLTI  = 6'h1a,
      OP_LW    = 6'h23,
      OP_SW    = 6'h2b,
      OP_HALT  = 6'h3f
   } opcode_e;

   // R-type function field
   typedef enum logic [5:0] {
      FN_SLL = 6'h04,
      FN_SRL = 6'h06,
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_XOR = 6'h26,
      FN_SLT = 6'h2a
   } funct_e;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_PASSB
   } alu_op_e;

   typedef struct packed {
      opcode_e    opcode;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [4:0] rd;
      logic [4:0] unused;
      funct_e     funct;
   } r_fmt_s;

   // rd of the I view shares bits 20:16 with rs2 of the R view
   typedef struct packed {
      opcode_e     opcode;
      logic [4:0]  rs1;
      logic [4:0]  rd;
      logic [15:0] imm16;
   } i_fmt_s;

   typedef union packed {
      r_fmt_s r;
      i_fmt_s i;
   } instr_u;

   // Decoded control travelling down the pipe
   typedef struct packed {
      logic       reg_write;
      logic       mem_read;
      logic       mem_write;
      logic       alu_src_imm;
      logic       halt;
      alu_op_e    alu_op;
      logic [4:0] dest;
   } ctrl_s;

endpackage

`default_nettype wire

// ==== hw/dlx_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dlx_params.svh"

module dlx_regfile (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [4:0]           rd_sel_a,
   input  logic [4:0]           rd_sel_b,
   input  logic                 wr_en,
   input  logic [4:0]           wr_sel,
   input  logic [`DLX_XLEN-1:0] wr_data,
   output logic [`DLX_XLEN-1:0] rd_data_a,
   output logic [`DLX_XLEN-1:0] rd_data_b
);

   logic [`DLX_XLEN-1:0] regs [`DLX_NREGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `DLX_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_sel != 5'd0) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // r0 is hardwired
   // A write in the same cycle passes straight through to the reader
   always_comb begin
      if (rd_sel_a == 5'd0) begin
         rd_data_a = '0;
      end else if (wr_en && wr_sel == rd_sel_a) begin
         rd_data_a = wr_data;
      end else begin
         rd_data_a = regs[rd_sel_a];
      end
      if (rd_sel_b == 5'd0) begin
         rd_data_b = '0;
      end else if (wr_en && wr_sel == rd_sel_b) begin
         rd_data_b = wr_data;
      end else begin
         rd_data_b = regs[rd_sel_b];
      end
   end

endmodule

`default_nettype wire

// ==== hw/dlx_stage_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dlx_params.svh"

interface dlx_stage_if;

   // ID/EX register contents
   logic                 ex_valid;
   dlx_pkg::ctrl_s       ex_ctrl;
   logic [4:0]           ex_rs1_sel;
   logic [4:0]           ex_rs2_sel;
   logic [`DLX_XLEN-1:0] ex_rs1_val;
   logic [`DLX_XLEN-1:0] ex_rs2_val;
   // Sign-extended in decode
   logic [`DLX_XLEN-1:0] ex_imm;

   // Feedback for forwarding and hazards
   logic [`DLX_XLEN-1:0] ex_result;
   logic                 mem_valid;
   dlx_pkg::ctrl_s       mem_ctrl;
   // Load data or ALU result of the memory stage
   logic [`DLX_XLEN-1:0] mem_value;
   logic                 wb_valid;
   dlx_pkg::ctrl_s       wb_ctrl;
   logic [`DLX_XLEN-1:0] wb_value;

   modport producer (
      output ex_valid, ex_ctrl, ex_rs1_sel, ex_rs2_sel, ex_rs1_val, ex_rs2_val, ex_imm,
      input  ex_result, mem_valid, mem_ctrl, mem_value, wb_valid, wb_ctrl, wb_value
   );

   modport consumer (
      input  ex_valid, ex_ctrl, ex_rs1_sel, ex_rs2_sel, ex_rs1_val, ex_rs2_val, ex_imm,
      output ex_result, mem_valid, mem_ctrl, mem_value, wb_valid, wb_ctrl, wb_value
   );

endinterface

`default_nettype wire

// ==== tests/dlx_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dlx_params.svh"

module dlx_cpu_tb;

   localparam int RESET_CYCLES = 16;
   localparam int HALT_TIMEOUT = 400;
   localparam int DRAIN_CYCLES = 12;

   logic                 clk;
   logic                 rst;
   logic                 imem_we;
   logic [`DLX_XLEN-1:0] imem_addr;
   logic [`DLX_XLEN-1:0] imem_wdata;
   logic                 retire_valid;
   logic [4:0]           retire_dest;
   logic [`DLX_XLEN-1:0] retire_data;
   logic                 store_valid;
   logic [`DLX_XLEN-1:0] store_addr;
   logic [`DLX_XLEN-1:0] store_data;
   logic                 halted;

   // Program image and expected records {present, dest, data} and {present, addr, data}
   logic [31:0] prog [$];
   logic [37:0] ret_q [$];
   logic [64:0] st_q [$];

   dlx_cpu_top dut_i (
      .clk          (clk),
      .rst          (rst),
      .imem_we      (imem_we),
      .imem_addr    (imem_addr),
      .imem_wdata   (imem_wdata),
      .retire_valid (retire_valid),
      .retire_dest  (retire_dest),
      .retire_data  (retire_data),
      .store_valid  (store_valid),
      .store_addr   (store_addr),
      .store_data   (store_data),
      .halted       (halted)
   );

   always #2 clk = ~clk;

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic show_retire_error(input logic [37:0] exp_rec);
      if (!exp_rec[37]) begin
         $display("Unexpected retire of r%0d at %0d ns with nothing left to retire",
                  retire_dest, $time);
      end else begin
         if (retire_dest !== exp_rec[36:32]) begin
            $display("** Error at %0d ns: retire_dest = %0d, expected %0d",
                     $time, retire_dest, exp_rec[36:32]);
         end
         if (retire_data !== exp_rec[31:0]) begin
            $display("** Error at %0d ns: retire_data = 0x%08h, expected 0x%08h",
                     $time, retire_data, exp_rec[31:0]);
         end
      end
      stop_run("retire check failed");
   endtask

   task automatic show_store_error(input logic [64:0] exp_rec);
      if (!exp_rec[64]) begin
         $display("Unexpected store to 0x%08h at %0d ns with no store left in the program",
                  store_addr, $time);
      end else begin
         if (store_addr !== exp_rec[63:32]) begin
            $display("** Error at %0d ns: store_addr = 0x%08h, expected 0x%08h",
                     $time, store_addr, exp_rec[63:32]);
         end
         if (store_data !== exp_rec[31:0]) begin
            $display("** Error at %0d ns: store_data = 0x%08h, expected 0x%08h",
                     $time, store_data, exp_rec[31:0]);
         end
      end
      stop_run("store check failed");
   endtask

   // Outputs are settled at the falling edge
   always @(negedge clk) begin : retire_check
      logic [37:0] exp_rec;
      if (!rst && retire_valid) begin
         exp_rec = '0;
         if (ret_q.size() != 0) begin
            exp_rec = ret_q.pop_front();
         end
         assert (exp_rec[37] && retire_dest === exp_rec[36:32]
                 && retire_data === exp_rec[31:0])
            else show_retire_error(exp_rec);
      end
   end

   always @(negedge clk) begin : store_check
      logic [64:0] exp_rec;
      if (!rst && store_valid) begin
         exp_rec = '0;
         if (st_q.size() != 0) begin
            exp_rec = st_q.pop_front();
         end
         assert (exp_rec[64] && store_addr === exp_rec[63:32]
                 && store_data === exp_rec[31:0])
            else show_store_error(exp_rec);
      end
   end

   function automatic logic [15:0] rand16();
      logic [31:0] r;
      r = $urandom();
      return r[15:0];
   endfunction

   // R format fields from the top are opcode, rs1, rs2, rd, unused and funct
   task automatic put_r(input logic [5:0] funct, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
      prog.push_back({dlx_pkg::OP_RTYPE, rs1, rs2, rd, 5'd0, funct});
   endtask

   // I format fields from the top are opcode, rs1, rd and imm16
   // For sw the rd field names the data register
   task automatic put_i(input logic [5:0] op, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [15:0] imm);
      prog.push_back({op, rs1, rd, imm});
   endtask

   // In-order ISA model that fills the expected queues
   task automatic run_model();
      logic [31:0] regs [`DLX_NREGS];
      logic [31:0] mem [`DLX_DMEM_WORDS];
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic [31:0] addr;
      logic [4:0]  dest;
      logic        wr;
      logic        done;
      int          steps;
      for (int i = 0; i < `DLX_NREGS; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < `DLX_DMEM_WORDS; i++) begin
         mem[i] = '0;
      end
      pc = '0;
      done = 1'b0;
      steps = 0;
      while (!done && steps < 2000) begin
         ins  = prog[pc[31:2]];
         a    = regs[ins[25:21]];
         b    = regs[ins[20:16]];
         imm  = {{16{ins[15]}}, ins[15:0]};
         addr = a + imm;
         wr   = 1'b1;
         dest = ins[20:16];
         res  = '0;
         pc   = pc + 32'd4;
         case (ins[31:26])
            dlx_pkg::OP_RTYPE: begin
               dest = ins[15:11];
               case (ins[5:0])
                  dlx_pkg::FN_ADD: res = a + b;
                  dlx_pkg::FN_SUB: res = a - b;
                  dlx_pkg::FN_AND: res = a & b;
                  dlx_pkg::FN_OR:  res = a | b;
                  dlx_pkg::FN_XOR: res = a ^ b;
                  dlx_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  dlx_pkg::FN_SLL: res = a << b[4:0];
                  dlx_pkg::FN_SRL: res = a >> b[4:0];
                  default:         wr = 1'b0;
               endcase
            end
            dlx_pkg::OP_ADDI: res = a + imm;
            dlx_pkg::OP_ANDI: res = a & imm;
            dlx_pkg::OP_ORI:  res = a | imm;
            dlx_pkg::OP_XORI: res = a ^ imm;
            dlx_pkg::OP_SLTI: res = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            dlx_pkg::OP_LW:   res = mem[addr[9:2]];
            dlx_pkg::OP_SW: begin
               wr = 1'b0;
               mem[addr[9:2]] = b;
               st_q.push_back({1'b1, addr, b});
            end
            dlx_pkg::OP_BEQZ: begin
               wr = 1'b0;
               if (a == '0) pc = pc + imm;
            end
            dlx_pkg::OP_BNEZ: begin
               wr = 1'b0;
               if (a != '0) pc = pc + imm;
            end
            dlx_pkg::OP_HALT: begin
               wr = 1'b0;
               done = 1'b1;
            end
            default: wr = 1'b0;
         endcase
         // r0 writes are architecturally lost
         if (wr && dest != 5'd0) begin
            regs[dest] = res;
            ret_q.push_back({1'b1, dest, res});
         end
         steps++;
      end
   endtask

   // Loads the program under reset and runs it to halt and beyond
   task automatic run_program(input string name);
      int cycles;
      run_model();
      @(posedge clk);
      #1;
      rst = 1'b1;
      cycles = 0;
      foreach (prog[i]) begin
         imem_we    = 1'b1;
         imem_addr  = i * 4;
         imem_wdata = prog[i];
         @(posedge clk);
         #1;
         cycles++;
      end
      imem_we = 1'b0;
      while (cycles < RESET_CYCLES) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      rst = 1'b0;
      assert (!halted) else stop_run($sformatf("%s: halted high right after reset", name));
      cycles = 0;
      while (!halted && cycles < HALT_TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (halted) else stop_run($sformatf("%s: halted never rose", name));
      // Nothing may retire or store after halt
      for (int i = 0; i < DRAIN_CYCLES; i++) begin
         @(posedge clk);
         #1;
         assert (halted) else stop_run($sformatf("%s: halted fell before reset", name));
      end
      assert (ret_q.size() == 0 && st_q.size() == 0)
         else stop_run($sformatf("%s: %0d retires and %0d stores never seen",
                                 name, ret_q.size(), st_q.size()));
      $display("Program %s done after %0d cycles", name, cycles);
   endtask

   task automatic build_alu_program();
      prog.delete();
      put_i(dlx_pkg::OP_ADDI, 5'd1, 5'd0, rand16());
      put_i(dlx_pkg::OP_ORI,  5'd1, 5'd1, rand16());
      put_i(dlx_pkg::OP_ADDI, 5'd2, 5'd0, rand16());
      put_i(dlx_pkg::OP_ORI,  5'd2, 5'd2, rand16());
      // Only the low five bits count as shift amount
      put_i(dlx_pkg::OP_ADDI, 5'd3, 5'd0, rand16());
      put_r(dlx_pkg::FN_ADD, 5'd4,  5'd1, 5'd2);
      put_r(dlx_pkg::FN_SUB, 5'd5,  5'd1, 5'd2);
      put_r(dlx_pkg::FN_AND, 5'd6,  5'd1, 5'd2);
      put_r(dlx_pkg::FN_OR,  5'd7,  5'd1, 5'd2);
      put_r(dlx_pkg::FN_XOR, 5'd8,  5'd1, 5'd2);
      put_r(dlx_pkg::FN_SLT, 5'd9,  5'd1, 5'd2);
      put_r(dlx_pkg::FN_SLT, 5'd10, 5'd2, 5'd1);
      put_r(dlx_pkg::FN_SLL, 5'd11, 5'd1, 5'd3);
      put_r(dlx_pkg::FN_SRL, 5'd12, 5'd1, 5'd3);
      put_i(dlx_pkg::OP_ADDI, 5'd13, 5'd1, rand16());
      put_i(dlx_pkg::OP_ANDI, 5'd14, 5'd1, rand16());
      put_i(dlx_pkg::OP_ORI,  5'd15, 5'd2, rand16());
      put_i(dlx_pkg::OP_XORI, 5'd16, 5'd2, rand16());
      put_i(dlx_pkg::OP_SLTI, 5'd17, 5'd1, rand16());
      put_i(dlx_pkg::OP_HALT, 5'd0, 5'd0, 16'h0);
   endtask

   task automatic build_forward_program();
      prog.delete();
      put_i(dlx_pkg::OP_ADDI, 5'd1, 5'd0, rand16());
      // Distances 1, 2 and 3 from the producer of r1
      put_i(dlx_pkg::OP_ADDI, 5'd2, 5'd1, rand16());
      put_i(dlx_pkg::OP_ADDI, 5'd3, 5'd1, rand16());
      put_r(dlx_pkg::FN_ADD, 5'd4, 5'd1, 5'd2);
      put_r(dlx_pkg::FN_SUB, 5'd5, 5'd4, 5'd3);
      put_r(dlx_pkg::FN_XOR, 5'd6, 5'd2, 5'd5);
      // r0 write is dropped and r0 still reads zero
      put_i(dlx_pkg::OP_ADDI, 5'd0, 5'd1, rand16());
      put_r(dlx_pkg::FN_ADD, 5'd7, 5'd0, 5'd1);
      put_r(dlx_pkg::FN_OR,  5'd8, 5'd0, 5'd0);
      put_i(dlx_pkg::OP_HALT, 5'd0, 5'd0, 16'h0);
   endtask

   task automatic build_memory_program();
      prog.delete();
      put_i(dlx_pkg::OP_ADDI, 5'd1, 5'd0, 16'd64);
      put_i(dlx_pkg::OP_ADDI, 5'd2, 5'd0, rand16());
      put_i(dlx_pkg::OP_ORI,  5'd2, 5'd2, rand16());
      put_i(dlx_pkg::OP_SW,   5'd2, 5'd1, 16'd0);
      put_i(dlx_pkg::OP_LW,   5'd3, 5'd1, 16'd0);
      put_r(dlx_pkg::FN_ADD, 5'd4, 5'd3, 5'd2);
      put_i(dlx_pkg::OP_SW,   5'd4, 5'd1, 16'd8);
      put_i(dlx_pkg::OP_LW,   5'd5, 5'd1, 16'd8);
      // Load feeding store data at a negative offset
      put_i(dlx_pkg::OP_SW,   5'd5, 5'd1, 16'hfffc);
      put_i(dlx_pkg::OP_LW,   5'd6, 5'd1, 16'd4);
      put_i(dlx_pkg::OP_ADDI, 5'd7, 5'd6, 16'd1);
      put_i(dlx_pkg::OP_HALT, 5'd0, 5'd0, 16'h0);
   endtask

   task automatic build_branch_program();
      prog.delete();
      put_i(dlx_pkg::OP_ADDI, 5'd1, 5'd0, rand16() | 16'h1);
      put_i(dlx_pkg::OP_BNEZ, 5'd0, 5'd1, 16'd4);
      put_i(dlx_pkg::OP_ADDI, 5'd2, 5'd0, 16'd111);
      put_i(dlx_pkg::OP_BEQZ, 5'd0, 5'd1, 16'd4);
      put_i(dlx_pkg::OP_ADDI, 5'd3, 5'd0, 16'd22);
      put_r(dlx_pkg::FN_SUB, 5'd4, 5'd1, 5'd1);
      put_i(dlx_pkg::OP_BEQZ, 5'd0, 5'd4, 16'd4);
      put_i(dlx_pkg::OP_ADDI, 5'd5, 5'd0, 16'd33);
      put_i(dlx_pkg::OP_SW,   5'd1, 5'd0, 16'd16);
      // Branches right behind a load
      put_i(dlx_pkg::OP_LW,   5'd6, 5'd0, 16'd16);
      put_i(dlx_pkg::OP_BNEZ, 5'd0, 5'd6, 16'd4);
      put_i(dlx_pkg::OP_ADDI, 5'd7, 5'd0, 16'd44);
      put_i(dlx_pkg::OP_LW,   5'd8, 5'd0, 16'd20);
      put_i(dlx_pkg::OP_BNEZ, 5'd0, 5'd8, 16'd4);
      put_i(dlx_pkg::OP_ADDI, 5'd9, 5'd0, 16'd55);
      put_i(dlx_pkg::OP_BEQZ, 5'd0, 5'd0, 16'd8);
      put_i(dlx_pkg::OP_ADDI, 5'd10, 5'd0, 16'd66);
      put_i(dlx_pkg::OP_ADDI, 5'd11, 5'd0, 16'd77);
      put_i(dlx_pkg::OP_ADDI, 5'd12, 5'd9, 16'hffff);
      // Countdown loop with a backward branch
      put_i(dlx_pkg::OP_ADDI, 5'd14, 5'd0, 16'd3);
      put_i(dlx_pkg::OP_ADDI, 5'd14, 5'd14, 16'hffff);
      put_i(dlx_pkg::OP_BNEZ, 5'd0, 5'd14, 16'hfff8);
      put_i(dlx_pkg::OP_HALT, 5'd0, 5'd0, 16'h0);
      put_i(dlx_pkg::OP_ADDI, 5'd13, 5'd0, 16'd99);
   endtask

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      imem_we    = 1'b0;
      imem_addr  = '0;
      imem_wdata = '0;
      void'($urandom(32'h8f689deb));
      build_alu_program();
      run_program("alu_a");
      build_alu_program();
      run_program("alu_b");
      build_forward_program();
      run_program("forward");
      build_memory_program();
      run_program("memory");
      build_branch_program();
      run_program("branch");
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire
